// File: Bender.yml
package:
  name: rvcore

sources:
  - files:
      - hw/rvPkg.sv
      - hw/fetchStage.sv
      - hw/decodeStage.sv
      - hw/executeStage.sv
      - hw/memoryStage.sv
      - hw/rvCore.sv
  - target: test
    files:
      - verif/wbChecker.sv
      - verif/tbRvCore.sv

// File: hw/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import rvPkg::*; (
    input  logic       clock,
    input  logic       rstN,
    input  wordT       ifPc,
    input  wordT       ifInstr,
    input  logic       wbValid,
    input  regIdxT     wbRd,
    input  wordT       wbData,
    input  wordT       memAlu,
    input  regIdxT     memRd,
    input  logic       memRegWrite,
    input  logic       memMemRead,
    output logic       stall,
    output logic       redirect,
    output wordT       redirectPc,
    output logic       exValid,
    output logic       exRegWrite,
    output logic       exMemRead,
    output logic       exMemWrite,
    output wbSelT      exWbSel,
    output logic [3:0] exAluOp,
    output logic       exUseImm,
    output regIdxT     exRs1,
    output regIdxT     exRs2,
    output regIdxT     exRd,
    output wordT       exOpA,
    output wordT       exOpB,
    output wordT       exImm,
    output wordT       exLink
);

    wordT regFile [32];

    opcodeT     opcode;
    regIdxT     rs1;
    regIdxT     rs2;
    regIdxT     rd;
    logic [2:0] funct3;
    wordT       immI;
    wordT       immS;
    wordT       immB;
    wordT       immJ;
    wordT       rs1Val;
    wordT       rs2Val;
    wordT       cmpA;
    wordT       cmpB;
    logic       known;
    logic       isBranch;
    logic       isJal;
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       useImm;
    wbSelT      wbSel;
    logic [3:0] aluCode;
    logic       taken;
    logic       loadUse;
    logic       branchExHaz;
    logic       branchMemHaz;

    // write-through so a same-cycle write is visible
    function automatic wordT readReg(regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        if (wbValid && wbRd == idx) begin
            return wbData;
        end
        return regFile[idx];
    endfunction

    assign opcode = opcodeT'(ifInstr[opcodeLo +: 7]);
    assign rd     = ifInstr[rdLo +: 5];
    assign funct3 = ifInstr[funct3Lo +: 3];
    assign rs1    = ifInstr[rs1Lo +: 5];
    assign rs2    = ifInstr[rs2Lo +: 5];

    assign immI = {{20{ifInstr[31]}}, ifInstr[31:20]};
    assign immS = {{20{ifInstr[31]}}, ifInstr[31:25], ifInstr[11:7]};
    assign immB = {{19{ifInstr[31]}}, ifInstr[31], ifInstr[7], ifInstr[30:25],
                   ifInstr[11:8], 1'b0};
    assign immJ = {{11{ifInstr[31]}}, ifInstr[31], ifInstr[19:12], ifInstr[20],
                   ifInstr[30:21], 1'b0};

    // aluCode is {funct7 bit 30, funct3}, mapped to an ALU op in execute
    always_comb begin
        known    = 1'b1;
        isBranch = 1'b0;
        isJal    = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        useImm   = 1'b0;
        wbSel    = wbAlu;
        aluCode  = 4'b0000;
        case (opcode)
            opReg: begin
                regWrite = 1'b1;
                aluCode  = {ifInstr[funct7Bit], funct3};
            end
            opImm: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                aluCode  = {1'b0, funct3};
            end
            opLoad: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                useImm   = 1'b1;
                wbSel    = wbMem;
            end
            opStore: begin
                memWrite = 1'b1;
                useImm   = 1'b1;
            end
            opBranch: isBranch = 1'b1;
            opJal: begin
                regWrite = 1'b1;
                isJal    = 1'b1;
                wbSel    = wbLink;
            end
            default: known = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (wbValid) begin
            regFile[wbRd] <= wbData;
        end
    end

    always_comb begin
        rs1Val = readReg(rs1);
        rs2Val = readReg(rs2);
    end

    // branch operands take the memory-stage result
    assign cmpA = (memRegWrite && memRd != '0 && memRd == rs1) ? memAlu : rs1Val;
    assign cmpB = (memRegWrite && memRd != '0 && memRd == rs2) ? memAlu : rs2Val;

    always_comb begin
        case (branchCondT'(funct3))
            brEq:    taken = cmpA == cmpB;
            brNe:    taken = cmpA != cmpB;
            brLt:    taken = $signed(cmpA) < $signed(cmpB);
            brGe:    taken = $signed(cmpA) >= $signed(cmpB);
            default: taken = 1'b0;
        endcase
    end

    assign loadUse = exValid && exMemRead && exRd != '0
                     && (exRd == rs1 || exRd == rs2);
    assign branchExHaz = isBranch && exValid && exRegWrite && exRd != '0
                         && (exRd == rs1 || exRd == rs2);
    assign branchMemHaz = isBranch && memMemRead && memRd != '0
                          && (memRd == rs1 || memRd == rs2);
    assign stall = loadUse || branchExHaz || branchMemHaz;

    assign redirect   = !stall && (isJal || (isBranch && taken));
    assign redirectPc = ifPc + (isJal ? immJ : immB);

    // stall sends a bubble
    always_ff @(posedge clock) begin
        if (!rstN || stall) begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else begin
            exValid    <= known;
            exRegWrite <= regWrite;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
        end
    end

    always_ff @(posedge clock) begin
        exWbSel  <= wbSel;
        exAluOp  <= aluCode;
        exUseImm <= useImm;
        exRs1    <= rs1;
        exRs2    <= rs2;
        exRd     <= rd;
        exOpA    <= rs1Val;
        exOpB    <= rs2Val;
        exImm    <= (opcode == opStore) ? immS : immI;
        exLink   <= ifPc + 32'd4;
    end

endmodule

// File: hw/executeStage.sv
`timescale 1ns/1ps

module executeStage import rvPkg::*; (
    input  logic       clock,
    input  logic       rstN,
    input  logic       exValid,
    input  logic       exRegWrite,
    input  logic       exMemRead,
    input  logic       exMemWrite,
    input  wbSelT      exWbSel,
    input  logic [3:0] exAluOp,
    input  logic       exUseImm,
    input  regIdxT     exRs1,
    input  regIdxT     exRs2,
    input  regIdxT     exRd,
    input  wordT       exOpA,
    input  wordT       exOpB,
    input  wordT       exImm,
    input  wordT       exLink,
    input  logic       wbValid,
    input  regIdxT     wbRd,
    input  wordT       wbData,
    output logic       memRegWrite,
    output logic       memMemRead,
    output logic       memMemWrite,
    output wbSelT      memWbSel,
    output regIdxT     memRd,
    output wordT       memAlu,
    output wordT       memStoreData,
    output wordT       memLink
);

    aluOpT aluOp;
    wordT  fwdA;
    wordT  fwdB;
    wordT  aluB;
    wordT  aluOut;
    wordT  result;

    // memory stage wins over write-back
    function automatic wordT forward(regIdxT rs, wordT regVal);
        if (memRegWrite && memRd != '0 && memRd == rs) begin
            return memAlu;
        end
        if (wbValid && wbRd == rs) begin
            return wbData;
        end
        return regVal;
    endfunction

    always_comb begin
        case (exAluOp)
            4'b1000: aluOp = aluSub;
            4'b0111: aluOp = aluAnd;
            4'b0110: aluOp = aluOr;
            4'b0001: aluOp = aluSll;
            4'b0101: aluOp = aluSrl;
            4'b1101: aluOp = aluSra;
            default: aluOp = aluAdd;
        endcase
    end

    always_comb begin
        fwdA = forward(exRs1, exOpA);
        fwdB = forward(exRs2, exOpB);
    end

    assign aluB = exUseImm ? exImm : fwdB;

    always_comb begin
        case (aluOp)
            aluSub:  aluOut = fwdA - aluB;
            aluAnd:  aluOut = fwdA & aluB;
            aluOr:   aluOut = fwdA | aluB;
            aluSll:  aluOut = fwdA << aluB[4:0];
            aluSrl:  aluOut = fwdA >> aluB[4:0];
            aluSra:  aluOut = wordT'($signed(fwdA) >>> aluB[4:0]);
            default: aluOut = fwdA + aluB;
        endcase
    end

    // jal carries its link so later forwards see the right value
    assign result = (exWbSel == wbLink) ? exLink : aluOut;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
        end else begin
            memRegWrite <= exValid && exRegWrite;
            memMemRead  <= exValid && exMemRead;
            memMemWrite <= exValid && exMemWrite;
        end
    end

    always_ff @(posedge clock) begin
        memWbSel     <= exWbSel;
        memRd        <= exRd;
        memAlu       <= result;
        memStoreData <= fwdB;
        memLink      <= exLink;
    end

endmodule

// File: hw/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import rvPkg::*; #(
    parameter int imemWords = 128
) (
    input  logic                         clock,
    input  logic                         rstN,
    input  logic                         imemWrEn,
    input  logic [$clog2(imemWords)-1:0] imemWrAddr,
    input  wordT                         imemWrData,
    input  logic                         stall,
    input  logic                         redirect,
    input  wordT                         redirectPc,
    output wordT                         ifPc,
    output wordT                         ifInstr
);

    localparam int addrBits = $clog2(imemWords);

    wordT imem [imemWords];
    wordT pc;
    wordT instr;

    // program load only while the core is held in reset
    always_ff @(posedge clock) begin
        if (!rstN && imemWrEn) begin
            imem[imemWrAddr] <= imemWrData;
        end
    end

    assign instr = imem[pc[2 +: addrBits]];

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= redirect ? redirectPc : pc + 32'd4;
        end
    end

    // a zero word decodes as a bubble
    always_ff @(posedge clock) begin
        if (!rstN || (redirect && !stall)) begin
            ifPc    <= '0;
            ifInstr <= '0;
        end else if (!stall) begin
            ifPc    <= pc;
            ifInstr <= instr;
        end
    end

endmodule

// File: hw/memoryStage.sv
`timescale 1ns/1ps

module memoryStage import rvPkg::*; #(
    parameter int dmemWords = 64
) (
    input  logic   clock,
    input  logic   rstN,
    input  logic   memRegWrite,
    input  logic   memMemRead,
    input  logic   memMemWrite,
    input  wbSelT  memWbSel,
    input  regIdxT memRd,
    input  wordT   memAlu,
    input  wordT   memStoreData,
    input  wordT   memLink,
    output logic   wbValid,
    output regIdxT wbRd,
    output wordT   wbData
);

    localparam int addrBits = $clog2(dmemWords);

    wordT                dmem [dmemWords];
    logic [addrBits-1:0] dmemIdx;
    wordT                loadData;
    wbSelT               wbSel;
    wordT                aluQ;
    wordT                loadQ;
    wordT                linkQ;

    // word addressed, low two bits ignored
    assign dmemIdx = memAlu[2 +: addrBits];

    always_ff @(posedge clock) begin
        if (memMemWrite) begin
            dmem[dmemIdx] <= memStoreData;
        end
    end

    assign loadData = memMemRead ? dmem[dmemIdx] : '0;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= memRegWrite && memRd != '0;
        end
    end

    always_ff @(posedge clock) begin
        wbSel <= memWbSel;
        wbRd  <= memRd;
        aluQ  <= memAlu;
        loadQ <= loadData;
        linkQ <= memLink;
    end

    always_comb begin
        case (wbSel)
            wbMem:   wbData = loadQ;
            wbLink:  wbData = linkQ;
            default: wbData = aluQ;
        endcase
    end

endmodule

// File: hw/rvCore.sv
`timescale 1ns/1ps

module rvCore import rvPkg::*; #(
    parameter int imemWords = 128,
    parameter int dmemWords = 64
) (
    input  logic                         clock,
    input  logic                         rstN,
    input  logic                         imemWrEn,
    input  logic [$clog2(imemWords)-1:0] imemWrAddr,
    input  wordT                         imemWrData,
    output logic                         wbValid,
    output regIdxT                       wbRd,
    output wordT                         wbData
);

    // fetch <-> decode
    wordT   ifPc;
    wordT   ifInstr;
    logic   stall;
    logic   redirect;
    wordT   redirectPc;

    // decode/execute register
    logic       exValid;
    logic       exRegWrite;
    logic       exMemRead;
    logic       exMemWrite;
    wbSelT      exWbSel;
    logic [3:0] exAluOp;
    logic       exUseImm;
    regIdxT     exRs1;
    regIdxT     exRs2;
    regIdxT     exRd;
    wordT       exOpA;
    wordT       exOpB;
    wordT       exImm;
    wordT       exLink;

    // execute/memory register
    logic   memRegWrite;
    logic   memMemRead;
    logic   memMemWrite;
    wbSelT  memWbSel;
    regIdxT memRd;
    wordT   memAlu;
    wordT   memStoreData;
    wordT   memLink;

    fetchStage #(
        .imemWords(imemWords)
    ) uFetch (.*);

    decodeStage uDecode (.*);

    executeStage uExecute (.*);

    memoryStage #(
        .dmemWords(dmemWords)
    ) uMemory (.*);

endmodule

// File: hw/rvPkg.sv
package rvPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSll,
        aluSrl,
        aluSra
    } aluOpT;

    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbLink
    } wbSelT;

    // funct3 values of the branches
    typedef enum logic [2:0] {
        brEq = 3'b000,
        brNe = 3'b001,
        brLt = 3'b100,
        brGe = 3'b101
    } branchCondT;

    localparam int unsigned opcodeLo  = 0;
    localparam int unsigned rdLo      = 7;
    localparam int unsigned funct3Lo  = 12;
    localparam int unsigned rs1Lo     = 15;
    localparam int unsigned rs2Lo     = 20;
    localparam int unsigned funct7Bit = 30;

endpackage

// File: tb.f
hw/rvPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/rvCore.sv
verif/wbChecker.sv
verif/tbRvCore.sv

// File: verif/tbRvCore.sv
`timescale 1ns/1ps

module tbRvCore
    import rvPkg::*;
();

    localparam int imemWords     = 128;
    localparam int dmemWords     = 64;
    localparam int halfPeriod    = 4;
    localparam int resetCycles   = 10;
    localparam int seed          = 32'hfa0b;
    localparam int finishTimeout = 2000;

    logic                         clock;
    logic                         rstN;
    logic                         imemWrEn;
    logic [$clog2(imemWords)-1:0] imemWrAddr;
    wordT                         imemWrData;
    logic                         wbValid;
    regIdxT                       wbRd;
    wordT                         wbData;
    logic                         checkDone;
    int                           errorCount;

    wordT programTable[$];

    always #halfPeriod clock = ~clock;

    // RV32I encoders
    function automatic wordT aluReg(input logic [6:0] f7, input logic [2:0] f3,
                                    input regIdxT rd, input regIdxT rs1, input regIdxT rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic wordT aluImm(input logic [2:0] f3, input regIdxT rd,
                                    input regIdxT rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic wordT loadWord(input regIdxT rd, input regIdxT rs1,
                                      input logic [11:0] off);
        return {off, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic wordT storeWord(input regIdxT rs2, input regIdxT rs1,
                                       input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic wordT branch(input logic [2:0] f3, input regIdxT rs1,
                                    input regIdxT rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic wordT jump(input regIdxT rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic buildProgram();
        // dependent ALU chain
        programTable.push_back(aluImm(3'b000, 5'd1, 5'd0, 12'd5));
        programTable.push_back(aluImm(3'b000, 5'd2, 5'd1, 12'd3));
        programTable.push_back(aluReg(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        programTable.push_back(aluReg(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        programTable.push_back(aluReg(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
        programTable.push_back(aluReg(7'h00, 3'b110, 5'd6, 5'd5, 5'd1));
        programTable.push_back(aluReg(7'h00, 3'b001, 5'd7, 5'd6, 5'd1));
        programTable.push_back(aluReg(7'h00, 3'b101, 5'd8, 5'd7, 5'd2));
        // -64
        programTable.push_back(aluImm(3'b000, 5'd9, 5'd0, 12'hfc0));
        programTable.push_back(aluReg(7'h20, 3'b101, 5'd10, 5'd9, 5'd8));
        programTable.push_back(aluImm(3'b111, 5'd11, 5'd10, 12'h0f0));
        programTable.push_back(aluImm(3'b110, 5'd12, 5'd11, 12'h005));
        // store, reload, then load-use
        programTable.push_back(aluImm(3'b000, 5'd13, 5'd0, 12'd16));
        programTable.push_back(storeWord(5'd12, 5'd13, 12'd4));
        programTable.push_back(loadWord(5'd14, 5'd13, 12'd4));
        programTable.push_back(aluReg(7'h00, 3'b000, 5'd15, 5'd14, 5'd12));
        // branch right behind its producer, equal to x2 only if forwarded
        programTable.push_back(aluImm(3'b000, 5'd16, 5'd0, 12'd8));
        programTable.push_back(branch(3'b000, 5'd16, 5'd2, 13'd8));
        programTable.push_back(aluImm(3'b000, 5'd20, 5'd0, 12'd99));
        programTable.push_back(branch(3'b001, 5'd16, 5'd1, 13'd8));
        programTable.push_back(aluImm(3'b000, 5'd21, 5'd0, 12'd98));
        programTable.push_back(branch(3'b100, 5'd9, 5'd1, 13'd8));
        programTable.push_back(aluImm(3'b000, 5'd22, 5'd0, 12'd97));
        // bge on a freshly loaded value
        programTable.push_back(loadWord(5'd17, 5'd13, 12'd4));
        programTable.push_back(branch(3'b101, 5'd17, 5'd12, 13'd8));
        programTable.push_back(aluImm(3'b000, 5'd23, 5'd0, 12'd96));
        // not taken
        programTable.push_back(branch(3'b000, 5'd1, 5'd2, 13'd8));
        programTable.push_back(aluImm(3'b000, 5'd24, 5'd0, 12'd55));
        programTable.push_back(jump(5'd25, 21'd12));
        programTable.push_back(aluImm(3'b000, 5'd26, 5'd0, 12'd1));
        programTable.push_back(aluImm(3'b000, 5'd27, 5'd0, 12'd2));
        programTable.push_back(aluImm(3'b000, 5'd28, 5'd25, 12'd1));
        // park the core
        programTable.push_back(jump(5'd0, 21'd0));
    endtask

    rvCore #(
        .imemWords(imemWords),
        .dmemWords(dmemWords)
    ) i_dut (
        .clock      (clock),
        .rstN       (rstN),
        .imemWrEn   (imemWrEn),
        .imemWrAddr (imemWrAddr),
        .imemWrData (imemWrData),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData)
    );

    wbChecker uChecker (
        .clock      (clock),
        .rstN       (rstN),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .done       (checkDone),
        .errorCount (errorCount)
    );

    initial begin
        int unsigned idle;
        int          waitCycles;
        clock      = 1'b0;
        rstN       = 1'b0;
        imemWrEn   = 1'b0;
        imemWrAddr = '0;
        imemWrData = '0;
        void'($urandom(seed));
        buildProgram();
        @(negedge clock);
        // load port only accepts writes while reset is held
        for (int i = 0; i < programTable.size(); i++) begin
            imemWrEn   = 1'b1;
            imemWrAddr = $bits(imemWrAddr)'(i);
            imemWrData = programTable[i];
            @(negedge clock);
            imemWrEn = 1'b0;
            idle     = $urandom_range(3, 0);
            repeat (idle) @(negedge clock);
        end
        repeat (resetCycles) @(negedge clock);
        rstN = 1'b1;
        waitCycles = 0;
        while (!checkDone && waitCycles < finishTimeout) begin
            @(negedge clock);
            waitCycles++;
        end
        if (!checkDone) begin
            $display("checker did not finish within %0d cycles", finishTimeout);
            $display("Simulation failed");
        end else if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verif/wbChecker.sv
`timescale 1ns/1ps

module wbChecker import rvPkg::*; (
    input  logic   clock,
    input  logic   rstN,
    input  logic   wbValid,
    input  regIdxT wbRd,
    input  wordT   wbData,
    output logic   done,
    output int     errorCount
);

    localparam int resetTimeout = 1000;
    localparam int wbTimeout    = 200;
    localparam int quietWindow  = 50;

    regIdxT expRd[$];
    wordT   expData[$];
    int     checked;

    task automatic addExpected(input regIdxT rd, input wordT value);
        expRd.push_back(rd);
        expData.push_back(value);
    endtask

    // retire order; skipped instructions write x20-x23, x26, x27
    task automatic buildExpected();
        addExpected(5'd1, 32'h0000_0005);
        addExpected(5'd2, 32'h0000_0008);
        addExpected(5'd3, 32'h0000_000d);
        addExpected(5'd4, 32'h0000_0008);
        addExpected(5'd5, 32'h0000_0008);
        addExpected(5'd6, 32'h0000_000d);
        addExpected(5'd7, 32'h0000_01a0);
        addExpected(5'd8, 32'h0000_0001);
        addExpected(5'd9, 32'hffff_ffc0);
        addExpected(5'd10, 32'hffff_ffe0);
        addExpected(5'd11, 32'h0000_00e0);
        addExpected(5'd12, 32'h0000_00e5);
        addExpected(5'd13, 32'h0000_0010);
        addExpected(5'd14, 32'h0000_00e5);
        addExpected(5'd15, 32'h0000_01ca);
        addExpected(5'd16, 32'h0000_0008);
        addExpected(5'd17, 32'h0000_00e5);
        addExpected(5'd24, 32'h0000_0037);
        // link of the jal at word 28
        addExpected(5'd25, 32'h0000_0074);
        addExpected(5'd28, 32'h0000_0075);
    endtask

    // sampled on the rising edge, before the DUT registers update
    initial begin
        int   waitCycles;
        logic timedOut;
        done       = 1'b0;
        errorCount = 0;
        checked    = 0;
        timedOut   = 1'b0;
        buildExpected();
        // outputs are unknown until the first edge applies reset
        @(posedge clock);
        waitCycles = 0;
        do begin
            @(posedge clock);
            waitCycles++;
            if (rstN === 1'b0 && wbValid !== 1'b0) begin
                $display("write-back valid raised while reset is held");
                errorCount++;
            end
        end while (rstN !== 1'b1 && waitCycles < resetTimeout);
        if (rstN !== 1'b1) begin
            $display("reset not released within %0d cycles", resetTimeout);
            errorCount++;
            timedOut = 1'b1;
        end
        for (int idx = 0; idx < expRd.size() && !timedOut; idx++) begin
            waitCycles = 0;
            @(posedge clock);
            while (wbValid !== 1'b1 && waitCycles < wbTimeout) begin
                @(posedge clock);
                waitCycles++;
            end
            if (wbValid !== 1'b1) begin
                $display("no write-back within %0d cycles, x%0d was next", wbTimeout,
                         expRd[idx]);
                errorCount++;
                timedOut = 1'b1;
            end else begin
                if (wbRd !== expRd[idx]) begin
                    $display("[FAIL] wbRd: expected 0x%h, got 0x%h (entry %0d)",
                             expRd[idx], wbRd, idx);
                    errorCount++;
                end
                if (wbData !== expData[idx]) begin
                    $display("[FAIL] wbData: expected 0x%h, got 0x%h (entry %0d)",
                             expData[idx], wbData, idx);
                    errorCount++;
                end
                checked++;
            end
        end
        // nothing else may retire
        if (!timedOut) begin
            for (waitCycles = 0; waitCycles < quietWindow; waitCycles++) begin
                @(posedge clock);
                if (wbValid !== 1'b0) begin
                    $display("extra write-back to x%0d after the last expected one", wbRd);
                    errorCount++;
                end
            end
        end
        $display("checked %0d of %0d write-backs, %0d errors", checked, expRd.size(),
                 errorCount);
        done = 1'b1;
    end

endmodule
